/* common/ps2_pkg.sv */
package ps2_pkg;

	// start + 8 data + parity + stop
	localparam int frame_bits = 11;

	localparam logic [7:0] break_prefix = 8'hF0;	// key release follows
	localparam logic [7:0] ext_prefix = 8'hE0;	// extended key follows

	// one received byte as seen after the stop bit
	typedef struct packed {
		logic [7:0] data;
		logic err;	// bad start, parity or stop
	} ps2_frame_t;

	// decoder state shown on the display
	typedef struct packed {
		logic [7:0] code;	// last make code
		logic [7:0] ascii;	// ascii of last make code
		logic [3:0] count_hi;	// release count, tens
		logic [3:0] count_lo;	// release count, ones
	} key_state_t;

endpackage

/* common/disp_pkg.sv */
package disp_pkg;

	// active low, a b c d e f g dp from bit 7 down
	typedef logic [7:0] seg_t;

	localparam seg_t seg_blank = 8'b11111111;

	// digit 5 on the left down to digit 0 on the right
	typedef struct packed {
		seg_t count_hi;
		seg_t count_lo;
		seg_t ascii_hi;
		seg_t ascii_lo;
		seg_t code_hi;
		seg_t code_lo;
	} seg_bank_t;

	function automatic seg_t hex_to_seg(input logic [3:0] hex);
		seg_t pat;
		case (hex)
			4'h0: pat = 8'b00000011;
			4'h1: pat = 8'b10011111;
			4'h2: pat = 8'b00100101;
			4'h3: pat = 8'b00001101;
			4'h4: pat = 8'b10011001;
			4'h5: pat = 8'b01001001;
			4'h6: pat = 8'b01000001;
			4'h7: pat = 8'b00011111;
			4'h8: pat = 8'b00000001;
			4'h9: pat = 8'b00011001;
			4'hA: pat = 8'b00010001;
			4'hB: pat = 8'b11000001;	// lower case b
			4'hC: pat = 8'b01100011;
			4'hD: pat = 8'b10000101;	// lower case d
			4'hE: pat = 8'b01100001;
			default: pat = 8'b01110001;	// F
		endcase
		return pat;
	endfunction

endpackage

/* ps2_rx/ps2_rx.sv */
`timescale 1ns/100ps

module ps2_rx #(
	parameter int idle_cycles = 4000
) (
	input logic clk,
	input logic resetn,
	input logic ps2_clk,
	input logic ps2_data,
	output ps2_pkg::ps2_frame_t frame,
	output logic frame_valid
);

	localparam int idle_w = $clog2(idle_cycles + 1);
	localparam int last_bit = ps2_pkg::frame_bits - 1;

	logic [2:0] clk_sync;	// two sync stages + edge stage
	logic [1:0] data_sync;
	logic fall;
	logic [3:0] bit_cnt;
	logic [ps2_pkg::frame_bits-1:0] buffer;
	logic [idle_w-1:0] idle_cnt;

	// keyboard clock idles high, so reset to ones avoids a false edge
	always_ff @(posedge clk) begin
		if (!resetn) begin
			clk_sync <= 3'b111;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
		end
	end

	always_ff @(posedge clk) begin
		data_sync <= {data_sync[0], ps2_data};
	end

	assign fall = clk_sync[2] & ~clk_sync[1];

	always_ff @(posedge clk) begin
		if (fall) begin
			buffer[bit_cnt] <= data_sync[1];	// lsb first
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			bit_cnt <= '0;
			frame_valid <= 1'b0;
			idle_cnt <= '0;
		end else begin
			frame_valid <= fall && (bit_cnt == last_bit);
			if (fall) begin
				idle_cnt <= '0;
				if (bit_cnt == last_bit) begin
					bit_cnt <= '0;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else if (bit_cnt == '0) begin
				idle_cnt <= '0;
			end else if (idle_cnt == idle_w'(idle_cycles - 1)) begin
				// keyboard went quiet mid frame, drop what we have
				bit_cnt <= '0;
				idle_cnt <= '0;
			end else begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	// buffer holds the whole frame while frame_valid is high
	assign frame.data = buffer[8:1];
	assign frame.err = buffer[0] | ~(^buffer[9:1]) | ~buffer[10];	// start, odd parity, stop

	a_valid_single: assert property (@(posedge clk) disable iff (!resetn)
		frame_valid |=> !frame_valid);

	a_bit_cnt_range: assert property (@(posedge clk) disable iff (!resetn)
		bit_cnt <= 4'd10);

endmodule

/* hw/key_decoder.sv */
`timescale 1ns/100ps

module key_decoder (
	input logic clk,
	input logic resetn,
	input logic frame_valid,
	input ps2_pkg::ps2_frame_t frame,
	input logic [7:0] ascii,
	output logic [7:0] code,
	output ps2_pkg::key_state_t key,
	output logic frame_err
);

	logic break_pend;	// F0 seen, next byte is a release
	logic good_byte;
	logic is_break;
	logic is_ext;

	assign good_byte = frame_valid && !frame.err;
	assign is_break = (frame.data == ps2_pkg::break_prefix);
	assign is_ext = (frame.data == ps2_pkg::ext_prefix);

	// lookup sees the candidate code in the same cycle it gets stored
	assign code = frame.data;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			break_pend <= 1'b0;
			key <= '0;
		end else if (good_byte) begin
			if (is_ext) begin
				break_pend <= break_pend;	// E0 F0 xx still counts as release
			end else if (is_break) begin
				break_pend <= 1'b1;
			end else if (break_pend) begin
				break_pend <= 1'b0;
				if (key.count_lo == 4'd9) begin
					key.count_lo <= 4'd0;
					if (key.count_hi == 4'd9) begin
						key.count_hi <= 4'd0;	// 99 wraps to 00
					end else begin
						key.count_hi <= key.count_hi + 4'd1;
					end
				end else begin
					key.count_lo <= key.count_lo + 4'd1;
				end
			end else begin
				key.code <= frame.data;
				key.ascii <= ascii;
			end
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (!resetn) begin
			frame_err <= 1'b0;
		end else if (frame_valid && frame.err) begin
			frame_err <= 1'b1;
		end
	end

	a_bcd_digits: assert property (@(posedge clk) disable iff (!resetn)
		(key.count_hi <= 4'd9) && (key.count_lo <= 4'd9));

endmodule

/* hw/ascii_map.sv */
`timescale 1ns/100ps

module ascii_map (
	input logic [7:0] code,
	output logic [7:0] ascii
);

	// scan code set 2, no shift state
	always_comb begin
		case (code)
			// number row
			8'h45: ascii = 8'h30;
			8'h16: ascii = 8'h31;
			8'h1E: ascii = 8'h32;
			8'h26: ascii = 8'h33;
			8'h25: ascii = 8'h34;
			8'h2E: ascii = 8'h35;
			8'h36: ascii = 8'h36;
			8'h3D: ascii = 8'h37;
			8'h3E: ascii = 8'h38;
			8'h46: ascii = 8'h39;
			// letters, upper case
			8'h1C: ascii = 8'h41;
			8'h32: ascii = 8'h42;
			8'h21: ascii = 8'h43;
			8'h23: ascii = 8'h44;
			8'h24: ascii = 8'h45;
			8'h2B: ascii = 8'h46;
			8'h29: ascii = 8'h20;	// space
			default: ascii = 8'h00;	// not in table
		endcase
	end

endmodule

/* hw/seg_display.sv */
`timescale 1ns/100ps

module seg_display (
	input ps2_pkg::key_state_t key,
	output disp_pkg::seg_bank_t seg
);

	logic hi_blank;

	// leading zero of the count is dark
	assign hi_blank = (key.count_hi == 4'd0);

	always_comb begin
		if (hi_blank) begin
			seg.count_hi = disp_pkg::seg_blank;
		end else begin
			seg.count_hi = disp_pkg::hex_to_seg(key.count_hi);
		end
		seg.count_lo = disp_pkg::hex_to_seg(key.count_lo);
	end

	always_comb begin
		seg.ascii_hi = disp_pkg::hex_to_seg(key.ascii[7:4]);
		seg.ascii_lo = disp_pkg::hex_to_seg(key.ascii[3:0]);
		seg.code_hi = disp_pkg::hex_to_seg(key.code[7:4]);
		seg.code_lo = disp_pkg::hex_to_seg(key.code[3:0]);
	end

endmodule

/* hw/ps2_keyboard.sv */
`timescale 1ns/100ps

module ps2_keyboard #(
	parameter int idle_cycles = 4000
) (
	input logic clk,
	input logic resetn,
	input logic ps2_clk,
	input logic ps2_data,
	output disp_pkg::seg_bank_t seg,
	output logic frame_err
);

	ps2_pkg::ps2_frame_t frame;
	logic frame_valid;
	logic [7:0] code;
	logic [7:0] ascii;
	ps2_pkg::key_state_t key;

	ps2_rx #(
		.idle_cycles(idle_cycles)
	) i_ps2_rx (
		.clk(clk),
		.resetn(resetn),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.frame(frame),
		.frame_valid(frame_valid)
	);

	key_decoder i_key_decoder (
		.clk(clk),
		.resetn(resetn),
		.frame_valid(frame_valid),
		.frame(frame),
		.ascii(ascii),
		.code(code),
		.key(key),
		.frame_err(frame_err)
	);

	ascii_map i_ascii_map (
		.code(code),
		.ascii(ascii)
	);

	seg_display i_seg_display (
		.key(key),
		.seg(seg)
	);

endmodule

/* testbench/tb_ps2_keyboard.sv */
`timescale 1ns/100ps

module tb_ps2_keyboard;

	localparam int idle_cycles = 400;
	localparam int half_bit = 10;	// clk cycles per keyboard clock half period
	localparam int byte_gap = 40;
	localparam int release_pairs = 105;
	localparam int bytes_sent = 3 + 2 * release_pairs + 2 + 1 + 5;
	localparam int margin_cycles = 2000;
	localparam logic [7:0] mapped_codes [17] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
		8'h36, 8'h3D, 8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h29};

	logic clk;
	logic resetn;
	logic ps2_clk;
	logic ps2_data;
	disp_pkg::seg_bank_t seg;
	logic frame_err;

	int errors;
	int tests_run;
	integer seed;
	int exp_count;	// release count model, 0..99
	logic [7:0] exp_code;
	logic [7:0] exp_ascii;
	logic exp_err;
	logic exp_break;

	ps2_keyboard #(
		.idle_cycles(idle_cycles)
	) i_dut (
		.clk(clk),
		.resetn(resetn),
		.ps2_clk(ps2_clk),
		.ps2_data(ps2_data),
		.seg(seg),
		.frame_err(frame_err)
	);

	always #20 clk = ~clk;

	function automatic logic [7:0] digit_pattern(input int d);
		logic [7:0] p;
		case (d)
			0: p = 8'h03;
			1: p = 8'h9F;
			2: p = 8'h25;
			3: p = 8'h0D;
			4: p = 8'h99;
			5: p = 8'h49;
			6: p = 8'h41;
			7: p = 8'h1F;
			8: p = 8'h01;
			9: p = 8'h19;
			10: p = 8'h11;
			11: p = 8'hC1;
			12: p = 8'h63;
			13: p = 8'h85;
			14: p = 8'h61;
			default: p = 8'h71;
		endcase
		return p;
	endfunction

	function automatic logic [7:0] scan_to_ascii(input logic [7:0] sc);
		logic [7:0] a;
		a = 8'h00;
		for (int i = 0; i < 10; i++) begin
			if (mapped_codes[i] == sc) a = 8'h30 + 8'(i);	// number row 0..9
		end
		for (int i = 10; i < 16; i++) begin
			if (mapped_codes[i] == sc) a = 8'h41 + 8'(i - 10);	// A..F
		end
		if (sc == 8'h29) a = 8'h20;
		return a;
	endfunction

	function automatic disp_pkg::seg_bank_t expected_bank();
		disp_pkg::seg_bank_t b;
		b.count_hi = (exp_count / 10 == 0) ? 8'hFF : digit_pattern(exp_count / 10);
		b.count_lo = digit_pattern(exp_count % 10);
		b.ascii_hi = digit_pattern(int'(exp_ascii[7:4]));
		b.ascii_lo = digit_pattern(int'(exp_ascii[3:0]));
		b.code_hi = digit_pattern(int'(exp_code[7:4]));
		b.code_lo = digit_pattern(int'(exp_code[3:0]));
		return b;
	endfunction

	task automatic compare_seg_bank(input string name, input disp_pkg::seg_bank_t exp,
			input disp_pkg::seg_bank_t act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("mismatch at %0t: %s expected %b actual %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_outputs();
		compare_seg_bank("seg", expected_bank(), seg);
		compare_flag("frame_err", exp_err, frame_err);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task automatic apply_reset();
		resetn = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		wait_cycles(8);
		resetn = 1'b1;
		wait_cycles(2);
		exp_count = 0;
		exp_code = 8'h00;
		exp_ascii = 8'h00;
		exp_err = 1'b0;
		exp_break = 1'b0;
	endtask

	// data changes while the keyboard clock is high
	task automatic send_bit(input logic b);
		ps2_data = b;
		wait_cycles(half_bit);
		ps2_clk = 1'b0;
		wait_cycles(half_bit);
		ps2_clk = 1'b1;
	endtask

	function automatic logic [10:0] build_frame(input logic [7:0] code, input logic bad_parity);
		logic par;
		par = ~(^code) ^ bad_parity;	// odd parity
		return {1'b1, par, code, 1'b0};
	endfunction

	task automatic update_model(input logic [7:0] code);
		if (code == 8'hE0) begin
			exp_break = exp_break;
		end else if (code == 8'hF0) begin
			exp_break = 1'b1;
		end else if (exp_break) begin
			exp_break = 1'b0;
			exp_count = (exp_count + 1) % 100;
		end else begin
			exp_code = code;
			exp_ascii = scan_to_ascii(code);
		end
	endtask

	task automatic send_byte(input logic [7:0] code, input logic bad_parity);
		logic [10:0] bits;
		bits = build_frame(code, bad_parity);
		for (int i = 0; i < 11; i++) begin
			send_bit(bits[i]);	// lsb first
		end
		wait_cycles(byte_gap);
		if (bad_parity) exp_err = 1'b1;
		else update_model(code);
	endtask

	task automatic send_partial(input logic [7:0] code, input int nbits);
		logic [10:0] bits;
		bits = build_frame(code, 1'b0);
		for (int i = 0; i < nbits; i++) begin
			send_bit(bits[i]);
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		$display("%s done, %0d errors", name, errors - errors_before);
	endtask

	task automatic reset_state();
		int e0;
		e0 = errors;
		check_outputs();
		finish_test("reset_state", e0);
	endtask

	task automatic make_codes();
		int e0;
		e0 = errors;
		send_byte(8'h16, 1'b0);
		check_outputs();
		send_byte(8'h1C, 1'b0);
		check_outputs();
		send_byte(8'h0D, 1'b0);	// not in table
		check_outputs();
		finish_test("make_codes", e0);
	endtask

	task automatic release_count();
		int e0;
		int idx;
		e0 = errors;
		for (int i = 0; i < release_pairs; i++) begin
			idx = $unsigned($random(seed)) % 17;
			send_byte(8'hF0, 1'b0);
			send_byte(mapped_codes[idx], 1'b0);
		end
		check_outputs();
		finish_test("release_count", e0);
	endtask

	task automatic bad_frame();
		int e0;
		e0 = errors;
		send_byte(8'h1E, 1'b1);
		check_outputs();
		send_byte(8'h2B, 1'b0);
		check_outputs();
		finish_test("bad_frame", e0);
	endtask

	task automatic idle_recovery();
		int e0;
		e0 = errors;
		apply_reset();	// clears the sticky error from bad_frame
		send_partial(8'h3E, 4);
		wait_cycles(idle_cycles + 100);
		send_byte(8'h25, 1'b0);
		check_outputs();
		finish_test("idle_recovery", e0);
	endtask

	task automatic extended_prefix();
		int e0;
		e0 = errors;
		send_byte(8'hE0, 1'b0);
		send_byte(8'h29, 1'b0);
		check_outputs();
		send_byte(8'hE0, 1'b0);
		send_byte(8'hF0, 1'b0);
		send_byte(8'h29, 1'b0);
		check_outputs();
		finish_test("extended_prefix", e0);
	endtask

	initial begin
		clk = 1'b0;
		resetn = 1'b0;
		ps2_clk = 1'b1;
		ps2_data = 1'b1;
		errors = 0;
		tests_run = 0;
		seed = 32'h59beef12;
		apply_reset();
		reset_state();
		make_codes();
		release_count();
		bad_frame();
		idle_recovery();
		extended_prefix();
		$display("%0d tests run, %0d errors", tests_run, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// about 260 clk cycles per byte on the wire
	initial begin
		repeat (bytes_sent * 260 + margin_cycles) @(posedge clk);
		$display("watchdog: the tests did not finish in the expected time");
		$display("Test failed");
		$finish;
	end

endmodule

/* ps2_keyboard.f */
common/ps2_pkg.sv
common/disp_pkg.sv
ps2_rx/ps2_rx.sv
hw/key_decoder.sv
hw/ascii_map.sv
hw/seg_display.sv
hw/ps2_keyboard.sv
testbench/tb_ps2_keyboard.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_ps2_keyboard
FILELIST ?= ps2_keyboard.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MSG ?= Test passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
